// File: mips_fetch_settings.svh
`ifndef MIPS_FETCH_SETTINGS_SVH
`define MIPS_FETCH_SETTINGS_SVH

// boot address after reset
// kseg1 boot rom region
`define RESET_PC 32'hBFC0_0000

// general exception vector with BEV set
`define EXC_ENTRANCE 32'hBFC0_0380

// two instructions per fetch
`define FETCH_STEP 8

// address and instruction width
`define WORD_BITS 32

// fetch data width
// low half is the instruction at pc
// high half is the instruction at pc+4
`define BUS_BITS 64

`endif

// File: mips_fetch_pkg.sv
`include "mips_fetch_settings.svh"

package mips_fetch_pkg;

    // address or single instruction
    typedef logic [`WORD_BITS-1:0] word_t;

    // one fetch beat, two instruction slots
    typedef logic [`BUS_BITS-1:0] bus_data_t;

    // redirect kinds
    // encoded in rising priority so a plain compare ranks them
    typedef enum logic [1:0] {
        REDIR_NONE   = 2'd0,
        REDIR_BRANCH = 2'd1,
        REDIR_ERET   = 2'd2,
        REDIR_EXC    = 2'd3
    } redirect_t;

    // exception tag carried with slot a
    typedef enum logic {
        FETCH_OK       = 1'b0,
        FETCH_ADDR_ERR = 1'b1
    } fetch_exc_t;

endpackage

// File: redirect_hold.sv
`timescale 1ns/10ps
`include "mips_fetch_settings.svh"

module redirect_hold (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  redirect_exc,
    input  logic                  redirect_eret,
    input  logic                  redirect_branch,
    input  mips_fetch_pkg::word_t epc,
    input  mips_fetch_pkg::word_t branch_target,
    input  mips_fetch_pkg::word_t pc,
    input  logic                  pc_move,
    output mips_fetch_pkg::word_t pc_next,
    output logic                  redirect_now
);
    import mips_fetch_pkg::*;

    redirect_t pulse_kind;
    word_t     pulse_target;
    redirect_t pend_kind;
    word_t     pend_target;
    word_t     pc_succ;

    // rank this cycle's pulses
    // exception beats eret beats branch
    always_comb begin
        if (redirect_exc) begin
            pulse_kind = REDIR_EXC;
        end else if (redirect_eret) begin
            pulse_kind = REDIR_ERET;
        end else if (redirect_branch) begin
            pulse_kind = REDIR_BRANCH;
        end else begin
            pulse_kind = REDIR_NONE;
        end
    end

    // target of the winning pulse
    always_comb begin
        case (pulse_kind)
            REDIR_EXC:  pulse_target = `EXC_ENTRANCE;
            REDIR_ERET: pulse_target = epc;
            default:    pulse_target = branch_target;
        endcase
    end

    // sequential successor, one pair ahead
    assign pc_succ = pc + word_t'(`FETCH_STEP);

    // pending redirect kind
    // held while the pc cannot move, dropped once it does
    always_ff @(posedge clk) begin
        if (reset) begin
            pend_kind <= REDIR_NONE;
        end else if (pc_move) begin
            pend_kind <= REDIR_NONE;
        end else if (pulse_kind != REDIR_NONE && pulse_kind >= pend_kind) begin
            pend_kind <= pulse_kind;
        end
    end

    // pending target follows the kind register
    always_ff @(posedge clk) begin
        if (!pc_move && pulse_kind != REDIR_NONE && pulse_kind >= pend_kind) begin
            pend_target <= pulse_target;
        end
    end

    // next pc choice
    // a live pulse wins over anything pending
    always_comb begin
        if (pulse_kind != REDIR_NONE) begin
            pc_next = pulse_target;
        end else if (pend_kind != REDIR_NONE) begin
            pc_next = pend_target;
        end else begin
            pc_next = pc_succ;
        end
    end

    // tells fetch that the next pc is off the sequential path
    assign redirect_now = (pulse_kind != REDIR_NONE) || (pend_kind != REDIR_NONE);

endmodule

// File: fetch_pc.sv
`timescale 1ns/10ps
`include "mips_fetch_settings.svh"

module fetch_pc (
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       decode_stall,
    input  logic                       iresp_addr_ok,
    input  logic                       redirect_any,
    input  logic                       redirect_now,
    input  mips_fetch_pkg::word_t      pc_next,
    output mips_fetch_pkg::word_t      pc,
    output mips_fetch_pkg::word_t      ireq_addr,
    output logic                       ireq_valid,
    output logic                       pc_move,
    output logic                       f1_valid,
    output mips_fetch_pkg::word_t      f1_pc,
    output mips_fetch_pkg::fetch_exc_t f1_exc
);
    import mips_fetch_pkg::*;

    logic       misaligned;
    logic       accepted;
    fetch_exc_t pc_exc;

    // word alignment check on the fetch pc
    assign misaligned = (pc[1:0] != 2'b00);

    // address error tag for the current pc
    assign pc_exc = misaligned ? FETCH_ADDR_ERR : FETCH_OK;

    // bus request
    // never issued for a misaligned pc
    assign ireq_addr  = pc;
    assign ireq_valid = !misaligned;

    // request taken by the bus this cycle
    assign accepted = ireq_valid && iresp_addr_ok;

    // pc may step once the bus took the address
    // a misaligned pc steps without any request
    // decode back-pressure freezes the whole front end
    assign pc_move = !decode_stall && (accepted || misaligned);

    // pc register
    // holds its value while waiting on the bus
    always_ff @(posedge clk) begin
        if (reset) begin
            pc <= `RESET_PC;
        end else if (pc_move) begin
            pc <= pc_next;
        end
    end

    // f1 valid bit
    // any redirect kills the entry behind it
    // bubble when the pc did not advance
    always_ff @(posedge clk) begin
        if (reset) begin
            f1_valid <= 1'b0;
        end else if (redirect_any || redirect_now) begin
            f1_valid <= 1'b0;
        end else if (!decode_stall) begin
            f1_valid <= pc_move;
        end
    end

    // f1 payload
    // pc of the outstanding request and its error tag
    always_ff @(posedge clk) begin
        if (!decode_stall) begin
            f1_pc  <= pc;
            f1_exc <= pc_exc;
        end
    end

endmodule

// File: instr_capture.sv
`timescale 1ns/10ps
`include "mips_fetch_settings.svh"

module instr_capture (
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       decode_stall,
    input  logic                       redirect_any,
    input  logic                       f1_valid,
    input  mips_fetch_pkg::word_t      f1_pc,
    input  mips_fetch_pkg::fetch_exc_t f1_exc,
    input  mips_fetch_pkg::bus_data_t  iresp_data,
    output logic                       out_valid_a,
    output mips_fetch_pkg::word_t      out_pc_a,
    output mips_fetch_pkg::word_t      out_instr_a,
    output mips_fetch_pkg::fetch_exc_t out_exc_a,
    output logic                       out_valid_b,
    output mips_fetch_pkg::word_t      out_pc_b,
    output mips_fetch_pkg::word_t      out_instr_b
);
    import mips_fetch_pkg::*;

    logic      saved;
    bus_data_t save_buf;
    bus_data_t raw;
    logic      addr_err;
    logic      take_save;
    word_t     instr_a;
    word_t     instr_b;

    // bus data is only there for one cycle
    // grab it in the first stalled cycle with a live f1 entry
    assign take_save = decode_stall && f1_valid && !saved;

    // save buffer state
    // emptied when decode moves again or on a redirect
    always_ff @(posedge clk) begin
        if (reset) begin
            saved <= 1'b0;
        end else if (redirect_any || !decode_stall) begin
            saved <= 1'b0;
        end else if (take_save) begin
            saved <= 1'b1;
        end
    end

    // raw word kept across the stall
    always_ff @(posedge clk) begin
        if (take_save) begin
            save_buf <= iresp_data;
        end
    end

    // saved copy wins over whatever the bus drives now
    assign raw = saved ? save_buf : iresp_data;

    // misaligned pc had no request, so no instruction either
    assign addr_err = (f1_exc == FETCH_ADDR_ERR);

    // slot split
    // low half at pc, high half at pc+4
    assign instr_a = addr_err ? '0 : raw[`WORD_BITS-1:0];
    assign instr_b = addr_err ? '0 : raw[`BUS_BITS-1:`WORD_BITS];

    // output valids
    // redirect flushes even under stall
    always_ff @(posedge clk) begin
        if (reset) begin
            out_valid_a <= 1'b0;
            out_valid_b <= 1'b0;
        end else if (redirect_any) begin
            out_valid_a <= 1'b0;
            out_valid_b <= 1'b0;
        end else if (!decode_stall) begin
            out_valid_a <= f1_valid;
            // slot b dropped behind an address error
            out_valid_b <= f1_valid && !addr_err;
        end
    end

    // output payload
    // frozen while decode stalls
    always_ff @(posedge clk) begin
        if (!decode_stall) begin
            out_pc_a    <= f1_pc;
            out_instr_a <= instr_a;
            out_exc_a   <= f1_exc;
            out_pc_b    <= f1_pc + word_t'(`WORD_BITS / 8);
            out_instr_b <= instr_b;
        end
    end

endmodule

// File: mips_fetch.sv
`timescale 1ns/10ps

module mips_fetch (
    input  logic                       clk,
    input  logic                       reset,
    output mips_fetch_pkg::word_t      ireq_addr,
    output logic                       ireq_valid,
    input  logic                       iresp_addr_ok,
    input  mips_fetch_pkg::bus_data_t  iresp_data,
    input  logic                       redirect_exc,
    input  logic                       redirect_eret,
    input  logic                       redirect_branch,
    input  mips_fetch_pkg::word_t      epc,
    input  mips_fetch_pkg::word_t      branch_target,
    input  logic                       decode_stall,
    output logic                       out_valid_a,
    output mips_fetch_pkg::word_t      out_pc_a,
    output mips_fetch_pkg::word_t      out_instr_a,
    output mips_fetch_pkg::fetch_exc_t out_exc_a,
    output logic                       out_valid_b,
    output mips_fetch_pkg::word_t      out_pc_b,
    output mips_fetch_pkg::word_t      out_instr_b
);
    import mips_fetch_pkg::*;

    word_t      pc;
    word_t      pc_next;
    logic       redirect_now;
    logic       redirect_any;
    logic       pc_move;
    logic       f1_valid;
    word_t      f1_pc;
    fetch_exc_t f1_exc;

    // any redirect this cycle flushes the in-flight stages
    assign redirect_any = redirect_exc | redirect_eret | redirect_branch;

    // next pc selection and pending redirects
    redirect_hold u_redirect_hold (
        .clk             (clk),
        .reset           (reset),
        .redirect_exc    (redirect_exc),
        .redirect_eret   (redirect_eret),
        .redirect_branch (redirect_branch),
        .epc             (epc),
        .branch_target   (branch_target),
        .pc              (pc),
        .pc_move         (pc_move),
        .pc_next         (pc_next),
        .redirect_now    (redirect_now)
    );

    // pc register, bus request and f1 stage
    fetch_pc u_fetch_pc (
        .clk           (clk),
        .reset         (reset),
        .decode_stall  (decode_stall),
        .iresp_addr_ok (iresp_addr_ok),
        .redirect_any  (redirect_any),
        .redirect_now  (redirect_now),
        .pc_next       (pc_next),
        .pc            (pc),
        .ireq_addr     (ireq_addr),
        .ireq_valid    (ireq_valid),
        .pc_move       (pc_move),
        .f1_valid      (f1_valid),
        .f1_pc         (f1_pc),
        .f1_exc        (f1_exc)
    );

    // f2 capture and decode handoff
    instr_capture u_instr_capture (
        .clk          (clk),
        .reset        (reset),
        .decode_stall (decode_stall),
        .redirect_any (redirect_any),
        .f1_valid     (f1_valid),
        .f1_pc        (f1_pc),
        .f1_exc       (f1_exc),
        .iresp_data   (iresp_data),
        .out_valid_a  (out_valid_a),
        .out_pc_a     (out_pc_a),
        .out_instr_a  (out_instr_a),
        .out_exc_a    (out_exc_a),
        .out_valid_b  (out_valid_b),
        .out_pc_b     (out_pc_b),
        .out_instr_b  (out_instr_b)
    );

endmodule

// File: mips_fetch_clkgen.sv
`timescale 1ns/10ps

module mips_fetch_clkgen (
    output logic clk,
    output logic reset
);

    // 10 ns period
    initial begin
        clk = 1'b0;
        forever begin
            #5 clk = ~clk;
        end
    end

    // reset held over the first four rising edges
    initial begin
        reset = 1'b1;
        repeat (4) @(posedge clk);
        #1;
        reset = 1'b0;
    end

endmodule

// File: mips_fetch_sva.sv
`timescale 1ns/10ps

module mips_fetch_sva (
    input logic                       clk,
    input logic                       reset,
    input mips_fetch_pkg::word_t      ireq_addr,
    input logic                       ireq_valid,
    input logic                       iresp_addr_ok,
    input logic                       redirect_exc,
    input logic                       redirect_eret,
    input logic                       redirect_branch,
    input logic                       decode_stall,
    input logic                       out_valid_a,
    input mips_fetch_pkg::word_t      out_pc_a,
    input mips_fetch_pkg::word_t      out_instr_a,
    input mips_fetch_pkg::fetch_exc_t out_exc_a,
    input logic                       out_valid_b,
    input mips_fetch_pkg::word_t      out_pc_b,
    input mips_fetch_pkg::word_t      out_instr_b
);

    logic redirect_any;
    // assertion failures so far
    int   fail_count = 0;

    assign redirect_any = redirect_exc | redirect_eret | redirect_branch;

    // no bus request for a misaligned pc
    assert property (@(posedge clk) disable iff (reset)
        ireq_valid |-> ireq_addr[1:0] == 2'b00)
        else begin
            $error("bus request for misaligned address");
            fail_count++;
        end

    // a waiting request keeps its address
    assert property (@(posedge clk) disable iff (reset)
        ireq_valid && !iresp_addr_ok && !redirect_any |=> $stable(ireq_addr))
        else begin
            $error("request address moved while waiting");
            fail_count++;
        end

    // decode sees a frozen pair under stall
    // payload only matters behind a valid bit
    assert property (@(posedge clk) disable iff (reset)
        decode_stall && !redirect_any |=> $stable(out_valid_a) && $stable(out_valid_b)
            && (!out_valid_a
                || ($stable(out_pc_a) && $stable(out_instr_a) && $stable(out_exc_a)))
            && (!out_valid_b || ($stable(out_pc_b) && $stable(out_instr_b))))
        else begin
            $error("outputs changed under decode stall");
            fail_count++;
        end

    // nothing handed to decode right after reset
    assert property (@(posedge clk) $fell(reset) |-> !out_valid_a && !out_valid_b)
        else begin
            $error("output valid set right after reset");
            fail_count++;
        end

endmodule

bind mips_fetch mips_fetch_sva u_sva (.*);

// File: mips_fetch_tb.sv
`timescale 1ns/10ps
`include "mips_fetch_settings.svh"

module mips_fetch_tb;
    import mips_fetch_pkg::*;

    // program image is the address scrambled with a fixed key
    localparam word_t INSTR_KEY    = 32'h5A3C_96E1;
    localparam int    WATCH_CYCLES = 6 * 400;
    localparam int    WAIT_LIMIT   = 200;

    logic       clk;
    logic       reset;
    word_t      ireq_addr;
    logic       ireq_valid;
    logic       iresp_addr_ok;
    bus_data_t  iresp_data;
    logic       redirect_exc;
    logic       redirect_eret;
    logic       redirect_branch;
    word_t      epc;
    word_t      branch_target;
    logic       decode_stall;
    logic       out_valid_a;
    logic       out_valid_b;
    word_t      out_pc_a;
    word_t      out_instr_a;
    word_t      out_pc_b;
    word_t      out_instr_b;
    fetch_exc_t out_exc_a;

    // bus refuses every request while set
    logic  refuse;
    // pc of the next pair decode should get
    word_t exp_pc;
    // rank of the redirect not yet seen at the outputs
    int    redir_rank;
    int    pairs_seen = 0;
    int    errors = 0;
    int    failed_tests = 0;
    int    errors_at_start;
    // assertion failures already added to the error count
    int    sva_fails_seen = 0;
    string test_name;

    mips_fetch_clkgen u_clkgen (.clk(clk), .reset(reset));

    mips_fetch u_dut (.*);

    // reference model of the program image
    function automatic word_t instr_word(input word_t addr);
        return addr ^ INSTR_KEY;
    endfunction

    task automatic report_mismatch(input string what, input word_t exp, input word_t act);
        $display("mismatch %s %s: expected %h, actual %h", test_name, what, exp, act);
        errors++;
    endtask

    // one pair leaving for decode
    task automatic check_pair();
        fetch_exc_t exp_exc;
        exp_exc = (exp_pc[1:0] != 2'b00) ? FETCH_ADDR_ERR : FETCH_OK;
        if (out_pc_a !== exp_pc)
            report_mismatch("pc_a", exp_pc, out_pc_a);
        if (out_exc_a !== exp_exc)
            report_mismatch("exc_a", word_t'(exp_exc), word_t'(out_exc_a));
        if (exp_exc == FETCH_ADDR_ERR) begin
            // no fetch behind an address error
            if (out_instr_a !== '0)
                report_mismatch("instr_a", '0, out_instr_a);
            if (out_valid_b !== 1'b0)
                report_mismatch("valid_b", 32'd0, word_t'(out_valid_b));
        end else begin
            if (out_valid_b !== 1'b1)
                report_mismatch("valid_b", 32'd1, word_t'(out_valid_b));
            if (out_pc_b !== exp_pc + 4)
                report_mismatch("pc_b", exp_pc + 4, out_pc_b);
            if (out_instr_a !== instr_word(exp_pc))
                report_mismatch("instr_a", instr_word(exp_pc), out_instr_a);
            if (out_instr_b !== instr_word(exp_pc + 4))
                report_mismatch("instr_b", instr_word(exp_pc + 4), out_instr_b);
        end
        exp_pc     = exp_pc + word_t'(`FETCH_STEP);
        redir_rank = 0;
    endtask

    // instruction memory
    // data comes back one cycle after the address is taken
    always @(posedge clk) begin
        logic  hit;
        word_t hit_addr;
        logic  ok_next;
        hit      = ireq_valid && iresp_addr_ok;
        hit_addr = ireq_addr;
        ok_next  = !refuse && ($urandom_range(0, 3) != 0);
        #1;
        iresp_addr_ok = ok_next;
        if (hit)
            iresp_data = {instr_word(hit_addr + 4), instr_word(hit_addr)};
        else
            iresp_data = {$urandom, $urandom};
    end

    // compare process
    always @(posedge clk) begin
        int    rank;
        word_t target;
        if (reset) begin
            exp_pc     = `RESET_PC;
            redir_rank = 0;
        end else begin
            if (ireq_valid && ireq_addr[1:0] != 2'b00) begin
                $display("error %s: bus request for misaligned address %h", test_name, ireq_addr);
                errors++;
            end
            // a pair is taken only on an unstalled edge
            if (out_valid_a && !decode_stall) begin
                check_pair();
                pairs_seen++;
            end
            // exception over eret over branch
            rank   = redirect_exc ? 3 : redirect_eret ? 2 : redirect_branch ? 1 : 0;
            target = redirect_exc ? `EXC_ENTRANCE : redirect_eret ? epc : branch_target;
            // equal or higher rank replaces the outstanding one
            if (rank != 0 && rank >= redir_rank) begin
                redir_rank = rank;
                exp_pc     = target;
            end
        end
    end

    // just past the next rising edge
    task automatic step(input int n = 1);
        repeat (n) begin
            @(posedge clk);
            #1;
        end
    endtask

    task automatic pulse_redirect(input logic exc, input logic eret, input logic branch,
                                  input word_t target);
        redirect_exc    = exc;
        redirect_eret   = eret;
        redirect_branch = branch;
        branch_target   = target;
        step();
        redirect_exc    = 1'b0;
        redirect_eret   = 1'b0;
        redirect_branch = 1'b0;
    endtask

    task automatic wait_pairs(input int n);
        int goal;
        int waited;
        goal   = pairs_seen + n;
        waited = 0;
        while (pairs_seen < goal && waited < WAIT_LIMIT) begin
            step();
            waited++;
        end
        if (pairs_seen < goal) begin
            $display("error %s: no pair reached decode for %0d cycles", test_name, WAIT_LIMIT);
            errors++;
        end
    endtask

    task automatic start_test(input string name);
        test_name       = name;
        errors_at_start = errors;
    endtask

    task automatic finish_test();
        int new_fails;
        // bound assertions that fired during this test
        new_fails      = u_dut.u_sva.fail_count - sva_fails_seen;
        sva_fails_seen = u_dut.u_sva.fail_count;
        errors         = errors + new_fails;
        if (errors == errors_at_start) begin
            $display("test %s: ok", test_name);
        end else begin
            $display("test %s: %0d errors", test_name, errors - errors_at_start);
            failed_tests++;
        end
    endtask

    initial begin
        void'($urandom(32'he62ae573));
        refuse          = 1'b0;
        redirect_exc    = 1'b0;
        redirect_eret   = 1'b0;
        redirect_branch = 1'b0;
        epc             = '0;
        branch_target   = '0;
        decode_stall    = 1'b0;
        iresp_addr_ok   = 1'b0;
        iresp_data      = '0;
        test_name       = "reset";
        wait (reset == 1'b0);
        step();

        start_test("boot_stream");
        wait_pairs(8);
        finish_test();

        start_test("branch");
        pulse_redirect(1'b0, 1'b0, 1'b1, 32'h8000_1000);
        wait_pairs(4);
        finish_test();

        start_test("priority");
        epc = 32'h8000_0180;
        pulse_redirect(1'b1, 1'b1, 1'b1, 32'h8000_1400);
        wait_pairs(2);
        pulse_redirect(1'b0, 1'b1, 1'b1, 32'h8000_1400);
        wait_pairs(2);
        finish_test();

        // redirects land while the bus holds the request
        start_test("stall_redirect");
        refuse = 1'b1;
        step(2);
        pulse_redirect(1'b0, 1'b0, 1'b1, 32'h8000_2000);
        step(4);
        refuse = 1'b0;
        wait_pairs(2);
        refuse = 1'b1;
        step(2);
        pulse_redirect(1'b0, 1'b0, 1'b1, 32'h8000_3000);
        step(2);
        pulse_redirect(1'b1, 1'b0, 1'b0, 32'h8000_3000);
        step(3);
        refuse = 1'b0;
        wait_pairs(2);
        finish_test();

        start_test("decode_stall");
        repeat (4) begin
            step($urandom_range(1, 4));
            decode_stall = 1'b1;
            step($urandom_range(3, 12));
            decode_stall = 1'b0;
        end
        wait_pairs(4);
        finish_test();

        start_test("misaligned");
        pulse_redirect(1'b0, 1'b0, 1'b1, 32'h8000_4002);
        wait_pairs(3);
        pulse_redirect(1'b1, 1'b0, 1'b0, 32'h8000_4002);
        wait_pairs(2);
        finish_test();

        $display("tests 6, failed %0d, errors %0d", failed_tests, errors);
        if (errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

    // watchdog sized from the test budget
    initial begin
        repeat (WATCH_CYCLES + 4) @(posedge clk);
        $display("timeout: run did not finish within %0d cycles", WATCH_CYCLES);
        $display("*** FAILED ***");
        $finish;
    end

endmodule

// File: mips_fetch.f
+incdir+.
mips_fetch_pkg.sv
redirect_hold.sv
fetch_pc.sv
instr_capture.sv
mips_fetch.sv
mips_fetch_clkgen.sv
mips_fetch_sva.sv
mips_fetch_tb.sv
